// File: project.f
hw/ioPkg.sv
hw/ioLinkIf.sv
hw/spiShifter.sv
hw/cmdDecoder.sv
hw/strobeSync.sv
hw/downloadRam.sv
hw/dataIoTop.sv
tb/dataIoTb.sv

// File: run.sh
#!/bin/sh
# build and run the file download port testbench with Verilator
# the simulator exits non-zero when the testbench stops with $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module dataIoTb \
	-f project.f \
	-o dataIoSim

./obj_dir/dataIoSim

// File: tb/dataIoTb.sv
// ***********************************************
// testbench for the file download port
// sends frames from a table over the serial link,
// checks writes, status levels and buffer readback
// ***********************************************

module dataIoTb;
	timeunit 1ns;
	timeprecision 100ps;
	import ioPkg::*;

	localparam int clkPeriod = 20;
	localparam int addrW = 8;
	localparam logic [addrW-1:0] firstAddr = 8'h10;
	localparam int rowCount = 10;

	// dut inputs
	logic clk;
	logic ss;
	logic sck;
	logic spiSel;
	logic sdi;
	logic [addrW-1:0] rdAddr;

	// dut outputs
	logic downloading;
	logic [addrW-1:0] size;
	byteT index;
	logic wr;
	logic [addrW-1:0] wrAddr;
	byteT wrData;
	byteT rdData;

	// ***********************************************
	// stimulus table
	// ***********************************************

	// name, command, payload length in bits, expected download level after the frame
	string rowName [rowCount];
	byteT rowCmd [rowCount];
	int rowBits [rowCount];
	logic rowLevel [rowCount];
	bit tableLoaded = 1'b0;

	// reference model of the decoder state
	logic [addrW-1:0] modelSize;
	byteT modelIndex;
	byteT shadow [2**addrW];
	// writes still owed by the dut, oldest first
	logic [addrW-1:0] expAddr [$];
	byteT expData [$];
	// addresses written by the frame in flight
	logic [addrW-1:0] frameAddrs [$];
	string curName;

	dataIoTop #(
		.startAddr(32'h10),
		.addrWidth(addrW)
	) DUT (
		.clk(clk),
		.ss(ss),
		.sck(sck),
		.spiSel(spiSel),
		.sdi(sdi),
		.downloading(downloading),
		.size(size),
		.index(index),
		.wr(wr),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ***********************************************
	// helpers
	// ***********************************************

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic setRow(input int row, input string name, input byteT cmd,
			input int bits, input logic level);
		rowName[row] = name;
		rowCmd[row] = cmd;
		rowBits[row] = bits;
		rowLevel[row] = level;
	endtask

	// one bit, sck low for two cycles then high for two
	task automatic sendBit(input logic value);
		@(posedge clk);
		sck <= 1'b0;
		sdi <= value;
		@(posedge clk);
		@(posedge clk);
		sck <= 1'b1;
		@(posedge clk);
	endtask

	// msb first, count below eight leaves a partial byte
	task automatic sendBits(input byteT value, input int count);
		for (int i = 7; i > 7 - count; i--) begin
			sendBit(value[i]);
		end
	endtask

	// effect of one complete payload byte under a command
	task automatic applyModel(input byteT cmd, input byteT value);
		if (cmd == cmdFileTx) begin
			if (value[0]) begin
				modelSize = firstAddr;
			end
		end else if (cmd == cmdFileTxDat) begin
			expAddr.push_back(modelSize);
			expData.push_back(value);
			frameAddrs.push_back(modelSize);
			shadow[modelSize] = value;
			// counter sticks at the last address
			if (modelSize != '1) begin
				modelSize = modelSize + 8'd1;
			end
		end else if (cmd == cmdFileIndex) begin
			modelIndex = value;
		end
	endtask

	task automatic sendFrame(input int row);
		byteT value;
		int fullBytes;
		int restBits;
		fullBytes = rowBits[row] / 8;
		restBits = rowBits[row] % 8;
		curName = rowName[row];
		frameAddrs.delete();
		@(posedge clk);
		spiSel <= 1'b0;
		@(posedge clk);
		sendBits(rowCmd[row], 8);
		for (int n = 0; n < fullBytes; n++) begin
			value = 8'($urandom);
			// level rides on bit 0, upper bits are noise
			if (rowCmd[row] == cmdFileTx) begin
				value[0] = rowLevel[row];
			end
			applyModel(rowCmd[row], value);
			sendBits(value, 8);
		end
		if (restBits != 0) begin
			value = 8'($urandom);
			sendBits(value, restBits);
		end
		@(posedge clk);
		sck <= 1'b0;
		@(posedge clk);
		spiSel <= 1'b1;
	endtask

	task automatic readBack(input string name, input logic [addrW-1:0] addr);
		@(posedge clk);
		rdAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		checkValue({name, " readback"}, 32'(shadow[addr]), 32'(rdData));
	endtask

	task automatic checkRow(input int row);
		// all owed writes seen by the monitor
		while (expAddr.size() != 0) begin
			@(negedge clk);
		end
		// levels settle three clk cycles after the last sck edge
		repeat (4) @(negedge clk);
		checkValue({rowName[row], " downloading"}, 32'(rowLevel[row]), 32'(downloading));
		checkValue({rowName[row], " size"}, 32'(modelSize), 32'(size));
		checkValue({rowName[row], " index"}, 32'(modelIndex), 32'(index));
		for (int k = 0; k < frameAddrs.size(); k++) begin
			readBack(rowName[row], frameAddrs[k]);
		end
	endtask

	// ***********************************************
	// write monitor
	// ***********************************************

	always @(negedge clk) begin : writeMonitor
		logic [addrW-1:0] addrNow;
		byteT dataNow;
		if (wr === 1'b1) begin
			if (expAddr.size() == 0) begin
				$display("unexpected write in %s at address %0h", curName, wrAddr);
				$display("TESTBENCH FAILED");
				$fatal(1, "write without a data byte");
			end else begin
				addrNow = expAddr.pop_front();
				dataNow = expData.pop_front();
				checkValue({curName, " wrAddr"}, 32'(addrNow), 32'(wrAddr));
				checkValue({curName, " wrData"}, 32'(dataNow), 32'(wrData));
			end
		end
	end

	// ***********************************************
	// watchdog
	// ***********************************************

	// four clk periods per bit, plus per byte readback and per frame gaps
	initial begin : watchdog
		longint totalBits;
		longint limitNs;
		wait (tableLoaded);
		totalBits = 0;
		for (int r = 0; r < rowCount; r++) begin
			totalBits += 8 + rowBits[r];
		end
		limitNs = (4 * totalBits + 3 * (totalBits / 8) + 16 * (rowCount + 1)) * clkPeriod;
		limitNs += 2000;
		#(limitNs);
		$display("run timed out after %0d ns before all frames were checked", limitNs);
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	end

	// ***********************************************
	// main sequence
	// ***********************************************

	initial begin
		clk = 1'b0;
		ss = 1'b1;
		sck = 1'b0;
		spiSel = 1'b1;
		sdi = 1'b0;
		rdAddr = '0;
		void'($urandom(32'h4362_89e3));
		modelSize = '0;
		modelIndex = '0;
		curName = "reset";

		setRow(0, "start", cmdFileTx, 8, 1'b1);
		setRow(1, "data8", cmdFileTxDat, 64, 1'b1);
		setRow(2, "index", cmdFileIndex, 8, 1'b1);
		setRow(3, "dataAfterIndex", cmdFileTxDat, 32, 1'b1);
		setRow(4, "info", cmdFileInfo, 24, 1'b1);
		setRow(5, "unknown", 8'h77, 16, 1'b1);
		// 0x1c up to 0xff is 228 bytes, four more land on 0xff
		setRow(6, "saturate", cmdFileTxDat, 232 * 8, 1'b1);
		setRow(7, "end", cmdFileTx, 8, 1'b0);
		// command byte then five stray bits
		setRow(8, "partial", cmdFileTxDat, 5, 1'b0);
		// stray bits of the last frame must not leak into this one
		setRow(9, "restart", cmdFileTx, 8, 1'b1);
		tableLoaded = 1'b1;

		repeat (8) @(posedge clk);
		ss <= 1'b0;
		// read port still shows its reset value here
		@(negedge clk);
		checkValue("reset downloading", 32'h0, 32'(downloading));
		checkValue("reset size", 32'h0, 32'(size));
		checkValue("reset index", 32'h0, 32'(index));
		checkValue("reset wr", 32'h0, 32'(wr));
		checkValue("reset rdData", 32'h0, 32'(rdData));

		for (int r = 0; r < rowCount; r++) begin
			sendFrame(r);
			checkRow(r);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: hw/dataIoTop.sv
// ***********************************************
// file download port top level
// serial link in, buffer writes and status out
// ***********************************************

module dataIoTop #(
	parameter int unsigned startAddr = 0,
	parameter int addrWidth = 16
) (
	input logic clk,
	input logic ss,

	// serial link from the io controller
	input logic sck,
	input logic spiSel,
	input logic sdi,

	// download status, clk domain
	output logic downloading,
	output logic [addrWidth-1:0] size,
	output ioPkg::byteT index,

	// write stream into the buffer
	output logic wr,
	output logic [addrWidth-1:0] wrAddr,
	output ioPkg::byteT wrData,

	// buffer readback
	input logic [addrWidth-1:0] rdAddr,
	output ioPkg::byteT rdData
);

	// ***********************************************
	// links between the stages
	// ***********************************************

	// sck domain, shifter to decoder
	byteLinkIf byteLink ();
	// decoder to the clk side
	fileLinkIf #(.addrWidth(addrWidth)) fileLink ();

	// ***********************************************
	// sck domain
	// ***********************************************

	spiShifter shifter (
		.sck(sck),
		.spiSel(spiSel),
		.sdi(sdi),
		.link(byteLink.shifterSide)
	);

	cmdDecoder #(
		.startAddr(startAddr),
		.addrWidth(addrWidth)
	) decoder (
		.sck(sck),
		.bytes(byteLink.decoderSide),
		.file(fileLink.decoderSide)
	);

	// ***********************************************
	// clk domain
	// ***********************************************

	strobeSync #(.addrWidth(addrWidth)) sync (
		.clk(clk),
		.ss(ss),
		.file(fileLink.syncSide),
		.downloading(downloading),
		.size(size),
		.index(index),
		.wr(wr),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	// buffer takes the synchronized write stream
	downloadRam #(.addrWidth(addrWidth)) ram (
		.clk(clk),
		.ss(ss),
		.wr(wr),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

endmodule

// File: hw/downloadRam.sv
// ***********************************************
// download buffer RAM
// one write port, one registered read port
// ***********************************************

module downloadRam #(
	parameter int addrWidth = 16
) (
	input logic clk,
	input logic ss,
	input logic wr,
	input logic [addrWidth-1:0] wrAddr,
	input ioPkg::byteT wrData,
	input logic [addrWidth-1:0] rdAddr,
	output ioPkg::byteT rdData
);
	import ioPkg::*;

	// one byte per address
	byteT mem [2**addrWidth];

	// write lands on the edge that closes the wr cycle
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wrAddr] <= wrData;
		end
	end

	// read data one cycle after the address
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			rdData <= '0;
		end else begin
			rdData <= mem[rdAddr];
		end
	end

endmodule

// File: hw/strobeSync.sv
// ***********************************************
// crossing from the sck domain into clk
// toggle becomes a one-cycle write, levels resync
// ***********************************************

module strobeSync #(
	parameter int addrWidth = 16
) (
	input logic clk,
	input logic ss,
	fileLinkIf.syncSide file,
	output logic downloading,
	output logic [addrWidth-1:0] size,
	output ioPkg::byteT index,
	output logic wr,
	output logic [addrWidth-1:0] wrAddr,
	output ioPkg::byteT wrData
);
	import ioPkg::*;

	// toggle chain, stage 0 is the metastable one
	logic [2:0] toggleSync;
	// toggle flipped between the last two stages
	logic wrEdge;

	// first stage of the level synchronizers
	logic downMeta;
	logic [addrWidth-1:0] sizeMeta;
	byteT indexMeta;

	assign wrEdge = toggleSync[2] ^ toggleSync[1];

	// ***********************************************
	// write strobe and write pair
	// ***********************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			toggleSync <= '0;
			wr <= 1'b0;
			wrAddr <= '0;
			wrData <= '0;
		end else begin
			toggleSync <= {toggleSync[1:0], file.wrToggle};
			wr <= wrEdge;
			// pair has been stable for two cycles by now
			if (wrEdge) begin
				wrAddr <= file.wrAddr;
				wrData <= file.wrData;
			end
		end
	end

	// ***********************************************
	// level synchronizers
	// ***********************************************

	// multi-bit values are only read while the link is quiet
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			downMeta <= 1'b0;
			sizeMeta <= '0;
			indexMeta <= '0;
			downloading <= 1'b0;
			size <= '0;
			index <= '0;
		end else begin
			downMeta <= file.downloading;
			sizeMeta <= file.size;
			indexMeta <= file.index;
			downloading <= downMeta;
			size <= sizeMeta;
			index <= indexMeta;
		end
	end

endmodule

// File: hw/cmdDecoder.sv
// ***********************************************
// command decoder in the sck domain
// tracks download level, buffer address and index
// ***********************************************

module cmdDecoder #(
	parameter int unsigned startAddr = 0,
	parameter int addrWidth = 16
) (
	input logic sck,
	byteLinkIf.decoderSide bytes,
	fileLinkIf.decoderSide file
);
	import ioPkg::*;

	// first buffer address at the start of a download
	localparam logic [addrWidth-1:0] firstAddr = addrWidth'(startAddr);

	// no reset exists in this domain
	// registers hold their values across frames, power-up values below
	byteT cmdReg = '0;
	logic downloadReg = 1'b0;
	logic [addrWidth-1:0] addrCnt = '0;
	byteT indexReg = '0;
	logic toggleReg = 1'b0;

	// write pair for the clk side
	logic [addrWidth-1:0] wrAddrReg;
	byteT wrDataReg;

	// qualified byte strobes
	logic cmdStb;
	logic payStb;

	assign cmdStb = bytes.active & bytes.cmdDone;
	assign payStb = bytes.active & bytes.payDone;

	// ***********************************************
	// command register
	// ***********************************************

	always_ff @(posedge sck) begin
		if (cmdStb) begin
			cmdReg <= bytes.byteVal;
		end
	end

	// ***********************************************
	// payload handling
	// ***********************************************

	always_ff @(posedge sck) begin
		if (payStb) begin
			case (cmdReg)
				cmdFileTx: begin
					// bit 0 opens or closes the download
					downloadReg <= bytes.byteVal[0];
					if (bytes.byteVal[0]) begin
						addrCnt <= firstAddr;
					end
				end
				cmdFileTxDat: begin
					// hand the byte over and flip the toggle
					wrAddrReg <= addrCnt;
					wrDataReg <= bytes.byteVal;
					toggleReg <= ~toggleReg;
					// stop at the top of the buffer
					if (addrCnt != '1) begin
						addrCnt <= addrCnt + 1'b1;
					end
				end
				cmdFileIndex: begin
					indexReg <= bytes.byteVal;
				end
				// file info and unknown codes are dropped
				default: begin
				end
			endcase
		end
	end

	// ***********************************************
	// outputs toward the clk domain
	// ***********************************************

	assign file.wrToggle = toggleReg;
	assign file.wrAddr = wrAddrReg;
	assign file.wrData = wrDataReg;
	assign file.downloading = downloadReg;
	assign file.index = indexReg;
	// the counter doubles as the byte count
	assign file.size = addrCnt;

endmodule

// File: hw/spiShifter.sv
// ***********************************************
// serial shifter in the sck domain
// builds command and payload bytes from sdi
// ***********************************************

module spiShifter (
	input logic sck,
	input logic spiSel,
	input logic sdi,
	byteLinkIf.shifterSide link
);
	import ioPkg::*;

	// bit position inside the frame
	// 0 to 7 is the command, then 8 to 15 for every payload byte
	logic [4:0] bitCnt;
	// earlier bits of the byte in flight, msb first
	logic [dataW-2:0] shiftReg;

	// ***********************************************
	// bit counter
	// ***********************************************

	// select high aborts the frame and any partial byte
	always_ff @(posedge sck or posedge spiSel) begin
		if (spiSel) begin
			bitCnt <= '0;
		end else if (bitCnt == payloadEndCount) begin
			// wrap back to the first payload bit
			bitCnt <= 5'(dataW);
		end else begin
			bitCnt <= bitCnt + 5'd1;
		end
	end

	// ***********************************************
	// shift register
	// ***********************************************

	// data path only, the counter decides what a byte means
	always_ff @(posedge sck) begin
		shiftReg <= {shiftReg[dataW-3:0], sdi};
	end

	// last bit is taken straight from sdi
	// so the byte is complete on the edge of its last bit
	assign link.byteVal = {shiftReg, sdi};

	// byte boundaries
	assign link.cmdDone = (bitCnt == cmdEndCount);
	assign link.payDone = (bitCnt == payloadEndCount);

	// select is active low on the link
	assign link.active = ~spiSel;

endmodule

// File: hw/ioLinkIf.sv
// ***********************************************
// byte link and file link between the stages
// byteLinkIf stays in sck, fileLinkIf crosses to clk
// ***********************************************

interface byteLinkIf;
	import ioPkg::*;

	// one sck pulse on the last command bit
	logic cmdDone;
	// one sck pulse on the last bit of each payload byte
	logic payDone;
	// finished byte, only meaningful during a pulse
	byteT byteVal;
	// frame in progress
	logic active;

	modport shifterSide (
		output cmdDone,
		output payDone,
		output byteVal,
		output active
	);

	modport decoderSide (
		input cmdDone,
		input payDone,
		input byteVal,
		input active
	);
endinterface

interface fileLinkIf #(parameter int addrWidth = 16);
	import ioPkg::*;

	// flips once per data byte
	logic wrToggle;
	// write pair, held until the next data byte
	logic [addrWidth-1:0] wrAddr;
	byteT wrData;
	// levels, sampled on the clk side
	logic downloading;
	byteT index;
	logic [addrWidth-1:0] size;

	modport decoderSide (output wrToggle, wrAddr, wrData, downloading, index, size);
	modport syncSide (input wrToggle, wrAddr, wrData, downloading, index, size);
endinterface

// File: hw/ioPkg.sv
// ***********************************************
// file download port shared definitions
// command codes, byte type and bit positions
// ***********************************************

package ioPkg;

	// payload byte width
	localparam int dataW = 8;

	// one byte as it travels the link
	typedef logic [dataW-1:0] byteT;

	// ***********************************************
	// io controller command codes
	// ***********************************************

	// start or end a download, payload bit 0 gives the level
	localparam byteT cmdFileTx = 8'h53;
	// one data byte for the buffer
	localparam byteT cmdFileTxDat = 8'h54;
	// menu index of the file
	localparam byteT cmdFileIndex = 8'h55;
	// file info, recognized and ignored
	localparam byteT cmdFileInfo = 8'h56;

	// bit counter value on the last bit of the command byte
	localparam logic [4:0] cmdEndCount = 5'd7;
	// bit counter value on the last bit of every payload byte
	localparam logic [4:0] payloadEndCount = 5'd15;

endpackage
